// File: logic/sq_consts.svh
`ifndef SQ_CONSTS_SVH
`define SQ_CONSTS_SVH

// Queue depth, must be a power of two
`define SQ_DEPTH 8

// Entry index width, log2 of the depth
`define SQ_IDX_W 3

// Stores per cycle on dispatch, execute and retire
`define SQ_ISSUE_W 2

// Doubleword address and store data
`define SQ_ADDR_W 29
`define SQ_DATA_W 64

`endif

// File: logic/sq_pkg.sv
`include "sq_consts.svh"

package sq_pkg;

  typedef logic [`SQ_IDX_W-1:0] sq_idx_t;

  // Address with the byte offset bits stripped
  typedef logic [`SQ_ADDR_W-1:0] sq_addr_t;

  typedef logic [`SQ_DATA_W-1:0] sq_data_t;

  typedef struct packed {
    sq_addr_t addr;
    sq_data_t data;
    logic     executed;
  } sq_entry_t;

  // Which of the two slots carry a store
  typedef enum logic [1:0] {
    SLOT_NONE = 2'b00,
    SLOT_0    = 2'b01,
    SLOT_1    = 2'b10,
    SLOT_BOTH = 2'b11
  } slot_mask_e;

endpackage

// File: logic/sq_alloc.sv
`timescale 1ns/1ps

module sq_alloc (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch_en,
  input  sq_pkg::slot_mask_e dispatch_mask,
  input  logic               rollback_en,
  input  sq_pkg::sq_idx_t    rollback_idx,
  input  sq_pkg::sq_idx_t    head,
  output logic               dispatch_ok,
  output sq_pkg::sq_idx_t    alloc_idx_0,
  output sq_pkg::sq_idx_t    alloc_idx_1,
  output sq_pkg::sq_idx_t    tail,
  output sq_pkg::slot_mask_e alloc_mask_fire
);

  sq_pkg::sq_idx_t tail_plus_one;
  sq_pkg::sq_idx_t tail_plus_two;
  sq_pkg::sq_idx_t tail_adv;
  logic            dispatch_fire;

  assign tail_plus_one = tail + 1'b1;
  assign tail_plus_two = tail + 2'd2;

  // One slot always stays empty, so a new index may never land on the head
  always_comb begin
    alloc_idx_0 = tail;
    alloc_idx_1 = tail_plus_one;
    tail_adv    = tail;
    dispatch_ok = 1'b1;
    case (dispatch_mask)
      sq_pkg::SLOT_0: begin
        tail_adv    = tail_plus_one;
        dispatch_ok = tail_plus_one != head;
      end
      sq_pkg::SLOT_1: begin
        alloc_idx_1 = tail;
        tail_adv    = tail_plus_one;
        dispatch_ok = tail_plus_one != head;
      end
      sq_pkg::SLOT_BOTH: begin
        tail_adv    = tail_plus_two;
        dispatch_ok = (tail_plus_one != head) && (tail_plus_two != head);
      end
      default: begin
        tail_adv = tail;
      end
    endcase
  end

  // Rollback wins over dispatch
  assign dispatch_fire   = dispatch_en && dispatch_ok && !rollback_en;
  assign alloc_mask_fire = dispatch_fire ? dispatch_mask : sq_pkg::SLOT_NONE;

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else if (rollback_en) begin
      tail <= rollback_idx;
    end else if (dispatch_fire) begin
      tail <= tail_adv;
    end
  end

endmodule

// File: logic/sq_entries.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module sq_entries (
  input  logic                               clock,
  input  logic                               reset,
  input  sq_pkg::slot_mask_e                 alloc_mask_fire,
  input  sq_pkg::sq_idx_t                    tail,
  input  logic [`SQ_ISSUE_W-1:0]             exec_valid,
  input  sq_pkg::sq_idx_t                    exec_idx_0,
  input  sq_pkg::sq_idx_t                    exec_idx_1,
  input  sq_pkg::sq_addr_t                   exec_addr_0,
  input  sq_pkg::sq_addr_t                   exec_addr_1,
  input  sq_pkg::sq_data_t                   exec_data_0,
  input  sq_pkg::sq_data_t                   exec_data_1,
  output sq_pkg::sq_entry_t [`SQ_DEPTH-1:0]  entries
);

  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] next_entries;
  sq_pkg::sq_idx_t                   tail_plus_one;

  assign tail_plus_one = tail + 1'b1;

  always_comb begin
    next_entries = entries;
    // Fresh entries start unexecuted
    case (alloc_mask_fire)
      sq_pkg::SLOT_0, sq_pkg::SLOT_1: begin
        next_entries[tail] = '0;
      end
      sq_pkg::SLOT_BOTH: begin
        next_entries[tail]          = '0;
        next_entries[tail_plus_one] = '0;
      end
      default: begin
        next_entries = entries;
      end
    endcase
    // Execute writes land last and so override a same-cycle clear
    if (exec_valid[0]) begin
      next_entries[exec_idx_0] = '{addr: exec_addr_0, data: exec_data_0, executed: 1'b1};
    end
    if (exec_valid[1]) begin
      next_entries[exec_idx_1] = '{addr: exec_addr_1, data: exec_data_1, executed: 1'b1};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entries <= '0;
    end else begin
      entries <= next_entries;
    end
  end

endmodule

// File: logic/sq_commit.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module sq_commit (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              retire_en,
  input  sq_pkg::slot_mask_e                retire_mask,
  input  sq_pkg::sq_idx_t                   tail,
  input  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries,
  output logic                              retire_ok,
  output sq_pkg::sq_idx_t                   head,
  output logic [`SQ_ISSUE_W-1:0]            mem_wr_en,
  output sq_pkg::sq_addr_t                  mem_addr_0,
  output sq_pkg::sq_addr_t                  mem_addr_1,
  output sq_pkg::sq_data_t                  mem_data_0,
  output sq_pkg::sq_data_t                  mem_data_1
);

  sq_pkg::sq_idx_t head_plus_one;
  sq_pkg::sq_idx_t occupancy;
  sq_pkg::sq_idx_t rd_idx_1;
  logic [1:0]      n_retire;
  logic            retire_fire;

  assign head_plus_one = head + 1'b1;
  assign occupancy     = tail - head;

  // Oldest store goes to the lowest requesting slot
  always_comb begin
    rd_idx_1  = head_plus_one;
    n_retire  = 2'd0;
    retire_ok = 1'b1;
    case (retire_mask)
      sq_pkg::SLOT_0: begin
        n_retire  = 2'd1;
        retire_ok = (occupancy != '0) && entries[head].executed;
      end
      sq_pkg::SLOT_1: begin
        rd_idx_1  = head;
        n_retire  = 2'd1;
        retire_ok = (occupancy != '0) && entries[head].executed;
      end
      sq_pkg::SLOT_BOTH: begin
        n_retire  = 2'd2;
        retire_ok = (occupancy >= sq_pkg::sq_idx_t'(2)) && entries[head].executed &&
                    entries[head_plus_one].executed;
      end
      default: begin
        n_retire = 2'd0;
      end
    endcase
  end

  assign retire_fire = retire_en && retire_ok;

  always_ff @(posedge clock) begin
    if (reset) begin
      head      <= '0;
      mem_wr_en <= '0;
    end else begin
      mem_wr_en <= '0;
      if (retire_fire) begin
        head      <= head + sq_pkg::sq_idx_t'(n_retire);
        mem_wr_en <= retire_mask;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (retire_fire) begin
      mem_addr_0 <= entries[head].addr;
      mem_data_0 <= entries[head].data;
      mem_addr_1 <= entries[rd_idx_1].addr;
      mem_data_1 <= entries[rd_idx_1].data;
    end
  end

endmodule

// File: logic/sq_forward.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module sq_forward (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              ld_valid,
  input  sq_pkg::sq_addr_t                  ld_addr,
  input  sq_pkg::sq_idx_t                   ld_sq_idx,
  input  sq_pkg::sq_idx_t                   head,
  input  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries,
  output logic                              fwd_valid,
  output logic                              fwd_hit,
  output sq_pkg::sq_data_t                  fwd_data
);

  // Number of stores older than the load
  sq_pkg::sq_idx_t  older;
  sq_pkg::sq_idx_t  probe;
  logic             found;
  sq_pkg::sq_data_t found_data;
  logic             hit;

  assign older = ld_sq_idx - head;

  // Youngest first, walking back toward the head
  always_comb begin
    found      = 1'b0;
    found_data = '0;
    probe      = ld_sq_idx;
    for (int j = 1; j < `SQ_DEPTH; j++) begin
      probe = ld_sq_idx - sq_pkg::sq_idx_t'(j);
      if (!found && (sq_pkg::sq_idx_t'(j) <= older) && entries[probe].executed &&
          (entries[probe].addr == ld_addr)) begin
        found      = 1'b1;
        found_data = entries[probe].data;
      end
    end
  end

  assign hit = ld_valid && found;

  always_ff @(posedge clock) begin
    if (reset) begin
      fwd_valid <= 1'b0;
      fwd_hit   <= 1'b0;
    end else begin
      fwd_valid <= ld_valid;
      fwd_hit   <= hit;
    end
  end

  // Zero on a miss
  always_ff @(posedge clock) begin
    fwd_data <= hit ? found_data : '0;
  end

endmodule

// File: logic/store_queue.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module store_queue (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_en,
  input  sq_pkg::slot_mask_e     dispatch_mask,
  output logic                   dispatch_ok,
  output sq_pkg::sq_idx_t        alloc_idx_0,
  output sq_pkg::sq_idx_t        alloc_idx_1,
  input  logic                   rollback_en,
  input  sq_pkg::sq_idx_t        rollback_idx,
  input  logic [`SQ_ISSUE_W-1:0] exec_valid,
  input  sq_pkg::sq_idx_t        exec_idx_0,
  input  sq_pkg::sq_idx_t        exec_idx_1,
  input  sq_pkg::sq_addr_t       exec_addr_0,
  input  sq_pkg::sq_addr_t       exec_addr_1,
  input  sq_pkg::sq_data_t       exec_data_0,
  input  sq_pkg::sq_data_t       exec_data_1,
  input  logic                   retire_en,
  input  sq_pkg::slot_mask_e     retire_mask,
  output logic                   retire_ok,
  output logic [`SQ_ISSUE_W-1:0] mem_wr_en,
  output sq_pkg::sq_addr_t       mem_addr_0,
  output sq_pkg::sq_addr_t       mem_addr_1,
  output sq_pkg::sq_data_t       mem_data_0,
  output sq_pkg::sq_data_t       mem_data_1,
  input  logic                   ld_valid,
  input  sq_pkg::sq_addr_t       ld_addr,
  input  sq_pkg::sq_idx_t        ld_sq_idx,
  output logic                   fwd_valid,
  output logic                   fwd_hit,
  output sq_pkg::sq_data_t       fwd_data
);

  sq_pkg::sq_idx_t                   head;
  sq_pkg::sq_idx_t                   tail;
  sq_pkg::slot_mask_e                alloc_mask_fire;
  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries;

  sq_alloc i_sq_alloc (
    .clock           (clock),
    .reset           (reset),
    .dispatch_en     (dispatch_en),
    .dispatch_mask   (dispatch_mask),
    .rollback_en     (rollback_en),
    .rollback_idx    (rollback_idx),
    .head            (head),
    .dispatch_ok     (dispatch_ok),
    .alloc_idx_0     (alloc_idx_0),
    .alloc_idx_1     (alloc_idx_1),
    .tail            (tail),
    .alloc_mask_fire (alloc_mask_fire)
  );

  sq_entries i_sq_entries (
    .clock           (clock),
    .reset           (reset),
    .alloc_mask_fire (alloc_mask_fire),
    .tail            (tail),
    .exec_valid      (exec_valid),
    .exec_idx_0      (exec_idx_0),
    .exec_idx_1      (exec_idx_1),
    .exec_addr_0     (exec_addr_0),
    .exec_addr_1     (exec_addr_1),
    .exec_data_0     (exec_data_0),
    .exec_data_1     (exec_data_1),
    .entries         (entries)
  );

  sq_commit i_sq_commit (
    .clock       (clock),
    .reset       (reset),
    .retire_en   (retire_en),
    .retire_mask (retire_mask),
    .tail        (tail),
    .entries     (entries),
    .retire_ok   (retire_ok),
    .head        (head),
    .mem_wr_en   (mem_wr_en),
    .mem_addr_0  (mem_addr_0),
    .mem_addr_1  (mem_addr_1),
    .mem_data_0  (mem_data_0),
    .mem_data_1  (mem_data_1)
  );

  sq_forward i_sq_forward (
    .clock     (clock),
    .reset     (reset),
    .ld_valid  (ld_valid),
    .ld_addr   (ld_addr),
    .ld_sq_idx (ld_sq_idx),
    .head      (head),
    .entries   (entries),
    .fwd_valid (fwd_valid),
    .fwd_hit   (fwd_hit),
    .fwd_data  (fwd_data)
  );

endmodule

// File: tb/store_queue_assertions.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module store_queue_assertions (
  input logic                   clock,
  input logic                   reset,
  input sq_pkg::slot_mask_e     dispatch_mask,
  input logic                   dispatch_ok,
  input sq_pkg::sq_idx_t        alloc_idx_0,
  input sq_pkg::sq_idx_t        alloc_idx_1,
  input sq_pkg::sq_idx_t        head,
  input logic                   retire_en,
  input logic                   retire_ok,
  input logic [`SQ_ISSUE_W-1:0] mem_wr_en,
  input logic                   ld_valid,
  input logic                   fwd_valid
);

  int fail_count = 0;

  // A data-cache write only follows an accepted retire
  assert property (@(posedge clock) disable iff (reset)
    (mem_wr_en != '0) |-> $past(retire_en && retire_ok))
    else begin
      $error("data-cache write without an accepted retire one cycle earlier");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset) ld_valid |=> fwd_valid)
    else begin
      $error("load query got no forwarding response one cycle later");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset) fwd_valid |-> $past(ld_valid))
    else begin
      $error("forwarding response without a load query one cycle earlier");
      fail_count++;
    end

  // An accepted pair needs two free entries before the head
  assert property (@(posedge clock) disable iff (reset)
    (dispatch_mask == sq_pkg::SLOT_BOTH) |->
      (alloc_idx_1 == sq_pkg::sq_idx_t'(alloc_idx_0 + 1'b1)) &&
      (!dispatch_ok ||
       (sq_pkg::sq_idx_t'(head - alloc_idx_0 - 1'b1) >= sq_pkg::sq_idx_t'(2))))
    else begin
      $error("pair allocation indices are not consecutive or the pair does not fit");
      fail_count++;
    end

endmodule

bind store_queue store_queue_assertions i_store_queue_assertions (.*);

// File: tb/store_queue_tests.svh
`ifndef STORE_QUEUE_TESTS_SVH
`define STORE_QUEUE_TESTS_SVH

task automatic fill_queue();
  logic accepted;
  int   accepts;
  int   tries;
  start_test("fill");
  accepted = 1'b1;
  accepts  = 0;
  tries    = 0;
  while (accepted && tries < TIMEOUT) begin
    // A pair must bounce when only one entry is left
    if (free_slots() == 1) begin
      dispatch_stores(sq_pkg::SLOT_BOTH, accepted);
      check_value("pair with one slot left", 0, accepted);
    end
    dispatch_stores(sq_pkg::SLOT_0, accepted);
    if (accepted) accepts++;
    tries++;
  end
  report_timeout(!accepted, "full queue");
  check_value("accepted stores", `SQ_DEPTH - 1, accepts);
  finish_test();
endtask

task automatic execute_and_retire();
  sq_pkg::sq_addr_t addr [2];
  sq_pkg::sq_data_t data [2];
  logic             accepted;
  start_test("execute_retire");
  for (int k = 0; k < 2; k++) begin
    addr[k] = rand_addr();
    data[k] = rand_data();
  end
  dispatch_stores(sq_pkg::SLOT_BOTH, accepted);
  exec_stores(2'b11, 3'd0, addr[0], data[0], 3'd1, addr[1], data[1]);
  retire_stores(sq_pkg::SLOT_BOTH, 1'b1);
  check_value("mem_wr_en", 2'b11, mem_wr_en);
  check_value("mem_addr_0", addr[0], mem_addr_0);
  check_value("mem_data_0", data[0], mem_data_0);
  check_value("mem_addr_1", addr[1], mem_addr_1);
  check_value("mem_data_1", data[1], mem_data_1);
  // Write port is a single-cycle pulse
  @(negedge clock);
  check_value("mem_wr_en after pulse", 0, mem_wr_en);
  finish_test();
endtask

task automatic retire_unexecuted();
  sq_pkg::sq_addr_t addr;
  sq_pkg::sq_data_t data;
  logic             accepted;
  start_test("retire_unexecuted");
  addr = rand_addr();
  data = rand_data();
  dispatch_stores(sq_pkg::SLOT_0, accepted);
  retire_stores(sq_pkg::SLOT_0, 1'b0);
  exec_stores(2'b01, 3'd0, addr, data, 3'd0, '0, '0);
  retire_stores(sq_pkg::SLOT_0, 1'b1);
  check_value("mem_wr_en", 2'b01, mem_wr_en);
  check_value("mem_addr_0", addr, mem_addr_0);
  check_value("mem_data_0", data, mem_data_0);
  finish_test();
endtask

task automatic forward_youngest();
  sq_pkg::sq_addr_t addr;
  sq_pkg::sq_data_t data [3];
  sq_pkg::sq_data_t fdata;
  logic             hit;
  logic             accepted;
  start_test("forward");
  addr = rand_addr();
  for (int k = 0; k < 3; k++) data[k] = rand_data();
  dispatch_stores(sq_pkg::SLOT_BOTH, accepted);
  dispatch_stores(sq_pkg::SLOT_0, accepted);
  exec_stores(2'b11, 3'd0, addr, data[0], 3'd1, addr, data[1]);
  exec_stores(2'b01, 3'd2, addr, data[2], 3'd0, '0, '0);
  // Load sits after store 1, so store 2 is younger and ignored
  query_forward(addr, 3'd2, hit, fdata);
  check_value("fwd_hit", 1, hit);
  check_value("fwd_data", data[1], fdata);
  query_forward(addr + 1'b1, model_tail, hit, fdata);
  check_value("fwd_hit unused address", 0, hit);
  check_value("fwd_data unused address", 0, fdata);
  query_forward(addr, model_head, hit, fdata);
  check_value("fwd_hit empty window", 0, hit);
  check_value("fwd_data empty window", 0, fdata);
  finish_test();
endtask

task automatic rollback_tail();
  sq_pkg::sq_addr_t addr [4];
  sq_pkg::sq_data_t data [4];
  sq_pkg::sq_data_t fdata;
  logic             hit;
  logic             accepted;
  start_test("rollback");
  addr[0] = rand_addr();
  for (int k = 0; k < 4; k++) begin
    addr[k] = addr[0] + sq_pkg::sq_addr_t'(k);
    data[k] = rand_data();
  end
  dispatch_stores(sq_pkg::SLOT_BOTH, accepted);
  dispatch_stores(sq_pkg::SLOT_BOTH, accepted);
  exec_stores(2'b11, 3'd0, addr[0], data[0], 3'd1, addr[1], data[1]);
  exec_stores(2'b11, 3'd2, addr[2], data[2], 3'd3, addr[3], data[3]);
  roll_back_to(3'd2);
  dispatch_stores(sq_pkg::SLOT_0, accepted);
  check_value("dispatch after rollback", 1, accepted);
  // Entry 2 is fresh and unexecuted, its old data must not come back
  query_forward(addr[2], model_tail, hit, fdata);
  check_value("fwd_hit reallocated entry", 0, hit);
  check_value("fwd_data reallocated entry", 0, fdata);
  finish_test();
endtask

`endif

// File: tb/store_queue_tb.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module store_queue_tb;

  localparam int TIMEOUT = 20;

  logic                   clock;
  logic                   reset;
  logic                   dispatch_en;
  sq_pkg::slot_mask_e     dispatch_mask;
  logic                   dispatch_ok;
  sq_pkg::sq_idx_t        alloc_idx_0;
  sq_pkg::sq_idx_t        alloc_idx_1;
  logic                   rollback_en;
  sq_pkg::sq_idx_t        rollback_idx;
  logic [`SQ_ISSUE_W-1:0] exec_valid;
  sq_pkg::sq_idx_t        exec_idx_0;
  sq_pkg::sq_idx_t        exec_idx_1;
  sq_pkg::sq_addr_t       exec_addr_0;
  sq_pkg::sq_addr_t       exec_addr_1;
  sq_pkg::sq_data_t       exec_data_0;
  sq_pkg::sq_data_t       exec_data_1;
  logic                   retire_en;
  sq_pkg::slot_mask_e     retire_mask;
  logic                   retire_ok;
  logic [`SQ_ISSUE_W-1:0] mem_wr_en;
  sq_pkg::sq_addr_t       mem_addr_0;
  sq_pkg::sq_addr_t       mem_addr_1;
  sq_pkg::sq_data_t       mem_data_0;
  sq_pkg::sq_data_t       mem_data_1;
  logic                   ld_valid;
  sq_pkg::sq_addr_t       ld_addr;
  sq_pkg::sq_idx_t        ld_sq_idx;
  logic                   fwd_valid;
  logic                   fwd_hit;
  sq_pkg::sq_data_t       fwd_data;

  // Reference copy of the queue pointers
  sq_pkg::sq_idx_t model_head;
  sq_pkg::sq_idx_t model_tail;

  integer seed = 32'h6e11455c;
  int     checks;
  int     errors;
  int     test_errors;
  string  current_test;

  store_queue i_store_queue (.*);

  always #10 clock = ~clock;

  task automatic drive_idle();
    dispatch_en   <= 1'b0;
    dispatch_mask <= sq_pkg::SLOT_NONE;
    rollback_en   <= 1'b0;
    rollback_idx  <= '0;
    exec_valid    <= '0;
    exec_idx_0    <= '0;
    exec_idx_1    <= '0;
    exec_addr_0   <= '0;
    exec_addr_1   <= '0;
    exec_data_0   <= '0;
    exec_data_1   <= '0;
    retire_en     <= 1'b0;
    retire_mask   <= sq_pkg::SLOT_NONE;
    ld_valid      <= 1'b0;
    ld_addr       <= '0;
    ld_sq_idx     <= '0;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    drive_idle();
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    model_head = '0;
    model_tail = '0;
  endtask

  task automatic start_test(input string name);
    current_test = name;
    test_errors  = 0;
    apply_reset();
  endtask

  task automatic finish_test();
    $display("test %s done, %0d errors", current_test, test_errors);
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAIL %s %s: expected %h, actual %h", current_test, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_timeout(input logic seen, input string what);
    checks++;
    assert (seen) else begin
      $display("ERROR %s: %s did not arrive within %0d cycles", current_test, what, TIMEOUT);
      errors++;
      test_errors++;
    end
  endtask

  // Concurrent assertion failures from the bound checker
  task automatic check_bound_assertions();
    int failures;
    failures = i_store_queue.i_store_queue_assertions.fail_count;
    checks++;
    assert (failures == 0) else begin
      $display("ERROR concurrent assertions failed %0d times", failures);
      errors++;
    end
  endtask

  function automatic int count_slots(input sq_pkg::slot_mask_e mask);
    return int'(mask[0]) + int'(mask[1]);
  endfunction

  // One entry always stays empty
  function automatic int free_slots();
    sq_pkg::sq_idx_t used;
    used = model_tail - model_head;
    return `SQ_DEPTH - 1 - int'(used);
  endfunction

  function automatic sq_pkg::sq_addr_t rand_addr();
    return sq_pkg::sq_addr_t'($random(seed));
  endfunction

  function automatic sq_pkg::sq_data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic dispatch_stores(input sq_pkg::slot_mask_e mask, output logic accepted);
    int   need;
    logic exp_ok;
    need   = count_slots(mask);
    exp_ok = need <= free_slots();
    @(posedge clock);
    dispatch_en   <= 1'b1;
    dispatch_mask <= mask;
    @(negedge clock);
    accepted = dispatch_ok;
    check_value("dispatch_ok", exp_ok, dispatch_ok);
    case (mask)
      sq_pkg::SLOT_0: check_value("alloc_idx_0", model_tail, alloc_idx_0);
      sq_pkg::SLOT_1: check_value("alloc_idx_1", model_tail, alloc_idx_1);
      sq_pkg::SLOT_BOTH: begin
        check_value("alloc_idx_0", model_tail, alloc_idx_0);
        check_value("alloc_idx_1", sq_pkg::sq_idx_t'(model_tail + 1'b1), alloc_idx_1);
      end
      default: ;
    endcase
    @(posedge clock);
    dispatch_en <= 1'b0;
    if (exp_ok) model_tail = model_tail + sq_pkg::sq_idx_t'(need);
  endtask

  task automatic exec_stores(input logic [1:0] valid,
                             input sq_pkg::sq_idx_t idx0, input sq_pkg::sq_addr_t addr0,
                             input sq_pkg::sq_data_t data0,
                             input sq_pkg::sq_idx_t idx1, input sq_pkg::sq_addr_t addr1,
                             input sq_pkg::sq_data_t data1);
    @(posedge clock);
    exec_valid  <= valid;
    exec_idx_0  <= idx0;
    exec_addr_0 <= addr0;
    exec_data_0 <= data0;
    exec_idx_1  <= idx1;
    exec_addr_1 <= addr1;
    exec_data_1 <= data1;
    @(posedge clock);
    exec_valid <= '0;
  endtask

  task automatic wait_mem_write();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < TIMEOUT && !seen; i++) begin
      @(negedge clock);
      seen = mem_wr_en != '0;
    end
    report_timeout(seen, "data-cache write");
  endtask

  task automatic retire_stores(input sq_pkg::slot_mask_e mask, input logic exp_ok);
    @(posedge clock);
    retire_en   <= 1'b1;
    retire_mask <= mask;
    @(negedge clock);
    check_value("retire_ok", exp_ok, retire_ok);
    @(posedge clock);
    retire_en <= 1'b0;
    if (exp_ok) begin
      model_head = model_head + sq_pkg::sq_idx_t'(count_slots(mask));
      wait_mem_write();
    end else begin
      @(negedge clock);
      check_value("mem_wr_en", 0, mem_wr_en);
    end
  endtask

  task automatic query_forward(input sq_pkg::sq_addr_t addr, input sq_pkg::sq_idx_t idx,
                               output logic hit, output sq_pkg::sq_data_t data);
    logic seen;
    seen = 1'b0;
    @(posedge clock);
    ld_valid  <= 1'b1;
    ld_addr   <= addr;
    ld_sq_idx <= idx;
    @(posedge clock);
    ld_valid <= 1'b0;
    for (int i = 0; i < TIMEOUT && !seen; i++) begin
      @(negedge clock);
      seen = fwd_valid;
    end
    report_timeout(seen, "forwarding response");
    hit  = fwd_hit;
    data = fwd_data;
  endtask

  task automatic roll_back_to(input sq_pkg::sq_idx_t idx);
    @(posedge clock);
    rollback_en  <= 1'b1;
    rollback_idx <= idx;
    @(posedge clock);
    rollback_en <= 1'b0;
    model_tail = idx;
  endtask

  `include "store_queue_tests.svh"

  initial begin
    clock  = 1'b0;
    checks = 0;
    errors = 0;
    reset <= 1'b1;
    drive_idle();
    fill_queue();
    execute_and_retire();
    retire_unexecuted();
    forward_youngest();
    rollback_tail();
    check_bound_assertions();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
+incdir+tb
logic/sq_pkg.sv
logic/sq_alloc.sv
logic/sq_entries.sv
logic/sq_commit.sv
logic/sq_forward.sv
logic/store_queue.sv
tb/store_queue_assertions.sv
tb/store_queue_tb.sv

// File: Bender.yml
package:
  name: store_queue

sources:
  - include_dirs:
      - logic
    files:
      - logic/sq_pkg.sv
      - logic/sq_alloc.sv
      - logic/sq_entries.sv
      - logic/sq_commit.sv
      - logic/sq_forward.sv
      - logic/store_queue.sv
  - target: test
    include_dirs:
      - logic
      - tb
    files:
      - tb/store_queue_assertions.sv
      - tb/store_queue_tb.sv
